// ==== Bender.yml ====
package:
  name: block_mover

sources:
  - logic/block_pkg.sv
  - logic/mem_port_if.sv
  - logic/chan_fifo_if.sv
  - logic/block_job_if.sv
  - logic/chan_fifo_bank.sv
  - logic/fill_mover.sv
  - logic/drain_mover.sv
  - logic/block_ram_arbiter.sv
  - logic/block_mover_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_block_mover.sv

// ==== flist.f ====
+incdir+sim
logic/block_pkg.sv
logic/mem_port_if.sv
logic/chan_fifo_if.sv
logic/block_job_if.sv
logic/chan_fifo_bank.sv
logic/fill_mover.sv
logic/drain_mover.sv
logic/block_ram_arbiter.sv
logic/block_mover_top.sv
sim/tb_block_mover.sv

// ==== logic/block_job_if.sv ====
`timescale 1ns/1ps

interface block_job_if;
  logic              req;
  block_pkg::chan_t  chan;
  block_pkg::addr_t  addr;    // Start address
  block_pkg::count_t count;   // Words requested
  logic              ack;
  block_pkg::count_t sent;    // Words moved

  modport host
  (
    output req, chan, addr, count,
    input  ack, sent
  );

  modport mover
  (
    input  req, chan, addr, count,
    output ack, sent
  );

endinterface

// ==== logic/block_mover_top.sv ====
`timescale 1ns/1ps

module block_mover_top
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic                           CLK_n,
  input  logic                           RST_MASTER,
  // --------------------
  input  logic                           i_in_push,
  input  block_pkg::chan_t               i_in_chan,
  input  block_pkg::word_t               i_in_data,
  output logic [block_pkg::NUM_CHAN-1:0] o_in_full,
  // --------------------
  input  logic                           i_out_pop,
  input  block_pkg::chan_t               i_out_chan,
  output block_pkg::word_t               o_out_data,
  output logic [block_pkg::NUM_CHAN-1:0] o_out_empty,
  // --------------------
  input  logic                           i_fill_req,
  input  block_pkg::chan_t               i_fill_chan,
  input  block_pkg::addr_t               i_fill_addr,
  input  block_pkg::count_t              i_fill_count,
  output logic                           o_fill_ack,
  output block_pkg::count_t              o_fill_sent,
  // --------------------
  input  logic                           i_drain_req,
  input  block_pkg::chan_t               i_drain_chan,
  input  block_pkg::addr_t               i_drain_addr,
  input  block_pkg::count_t              i_drain_count,
  output logic                           o_drain_ack,
  output block_pkg::count_t              o_drain_sent
);

  chan_fifo_if in_fifo();
  chan_fifo_if out_fifo();
  block_job_if fill_job();
  block_job_if drain_job();
  mem_port_if  fill_mem();
  mem_port_if  drain_mem();

  // Inbound writer and outbound reader come from the pins
  assign in_fifo.push      = i_in_push;
  assign in_fifo.push_chan = i_in_chan;
  assign in_fifo.push_data = i_in_data;
  assign o_in_full         = in_fifo.full;

  assign out_fifo.pop      = i_out_pop;
  assign out_fifo.pop_chan = i_out_chan;
  assign o_out_data        = out_fifo.pop_data;
  assign o_out_empty       = out_fifo.empty;

  assign fill_job.req    = i_fill_req;
  assign fill_job.chan   = i_fill_chan;
  assign fill_job.addr   = i_fill_addr;
  assign fill_job.count  = i_fill_count;
  assign o_fill_ack      = fill_job.ack;
  assign o_fill_sent     = fill_job.sent;

  assign drain_job.req   = i_drain_req;
  assign drain_job.chan  = i_drain_chan;
  assign drain_job.addr  = i_drain_addr;
  assign drain_job.count = i_drain_count;
  assign o_drain_ack     = drain_job.ack;
  assign o_drain_sent    = drain_job.sent;

  chan_fifo_bank #(.FIFO_DEPTH(FIFO_DEPTH)) in_bank
    (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .wr(in_fifo), .rd(in_fifo));

  chan_fifo_bank #(.FIFO_DEPTH(FIFO_DEPTH)) out_bank
    (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .wr(out_fifo), .rd(out_fifo));

  fill_mover fill
    (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .job(fill_job), .src(in_fifo), .mem(fill_mem));

  drain_mover drain
    (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .job(drain_job), .mem(drain_mem), .dst(out_fifo));

  block_ram_arbiter ram_arb
    (.CLK_n(CLK_n), .RST_MASTER(RST_MASTER), .fill_port(fill_mem), .drain_port(drain_mem));

endmodule

// ==== logic/block_pkg.sv ====
package block_pkg;

  // --------------------
  // Widths and sizes
  // --------------------
  localparam int WORD_W   = 32;
  localparam int ADDR_W   = 9;   // 512 words, wraps
  localparam int COUNT_W  = 6;
  localparam int CHAN_W   = 2;
  localparam int NUM_CHAN = 4;

  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [CHAN_W-1:0]  chan_t;

  // --------------------
  // State machines
  // --------------------
  typedef enum logic [2:0] {IDLE, LOAD, MEM_REQ, MEM_WAIT, DONE} mover_state_t;

  typedef enum logic [1:0] {ARB_IDLE, ARB_SERVE, ARB_RELEASE} arb_state_t;

endpackage

// ==== logic/block_ram_arbiter.sv ====
`timescale 1ns/1ps

module block_ram_arbiter
(
  input  logic        CLK_n,
  input  logic        RST_MASTER,
  mem_port_if.arbiter fill_port,
  mem_port_if.arbiter drain_port
);

  localparam int MEM_WORDS = 2 ** block_pkg::ADDR_W;

  block_pkg::word_t      ram_q [MEM_WORDS];
  block_pkg::arb_state_t state_q;
  block_pkg::word_t      rdata_q;
  logic                  last_grant_q;   // Set for drain, holds the current grant
  logic                  fill_ack_q;
  logic                  drain_ack_q;
  logic                  pick;
  logic                  sel_req;
  logic                  sel_we;
  block_pkg::addr_t      sel_addr;
  block_pkg::word_t      sel_wdata;

  // Tie goes to the port not served last
  assign pick = drain_port.req && (!fill_port.req || !last_grant_q);

  always_comb
  begin
    sel_req   = last_grant_q ? drain_port.req   : fill_port.req;
    sel_we    = last_grant_q ? drain_port.we    : fill_port.we;
    sel_addr  = last_grant_q ? drain_port.addr  : fill_port.addr;
    sel_wdata = last_grant_q ? drain_port.wdata : fill_port.wdata;
  end

  assign fill_port.ack   = fill_ack_q;
  assign drain_port.ack  = drain_ack_q;
  assign fill_port.rdata  = rdata_q;
  assign drain_port.rdata = rdata_q;

  always_ff @(posedge CLK_n)
    if (state_q == block_pkg::ARB_SERVE)
    begin
      if (sel_we)
        ram_q[sel_addr] <= sel_wdata;
      rdata_q <= ram_q[sel_addr];
    end

  // --------------------
  // Grant FSM
  // --------------------
  always_ff @(posedge CLK_n)
  begin
    if (!RST_MASTER)
    begin
      state_q      <= block_pkg::ARB_IDLE;
      last_grant_q <= 1'b0;
      fill_ack_q   <= 1'b0;
      drain_ack_q  <= 1'b0;
    end
    else
    begin
      case (state_q)
        block_pkg::ARB_IDLE:
          if (fill_port.req || drain_port.req)
          begin
            last_grant_q <= pick;
            state_q      <= block_pkg::ARB_SERVE;
          end
        block_pkg::ARB_SERVE:
        begin
          fill_ack_q  <= !last_grant_q;
          drain_ack_q <= last_grant_q;
          state_q     <= block_pkg::ARB_RELEASE;
        end
        block_pkg::ARB_RELEASE:
          if (!sel_req)
          begin
            fill_ack_q  <= 1'b0;
            drain_ack_q <= 1'b0;
            state_q     <= block_pkg::ARB_IDLE;
          end
        default:
          state_q <= block_pkg::ARB_IDLE;
      endcase
    end
  end

  a_fill_req_held: assert property (@(posedge CLK_n) disable iff (!RST_MASTER)
    fill_port.req && !fill_port.ack |=> fill_port.req)
    else $error("Fill request dropped before ack");

  a_drain_req_held: assert property (@(posedge CLK_n) disable iff (!RST_MASTER)
    drain_port.req && !drain_port.ack |=> drain_port.req)
    else $error("Drain request dropped before ack");

endmodule

// ==== logic/chan_fifo_bank.sv ====
`timescale 1ns/1ps

module chan_fifo_bank
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic         CLK_n,
  input  logic         RST_MASTER,
  chan_fifo_if.bank_wr wr,
  chan_fifo_if.bank_rd rd
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  block_pkg::word_t               mem_q    [block_pkg::NUM_CHAN][FIFO_DEPTH];
  logic [PTR_W-1:0]               wr_ptr_q [block_pkg::NUM_CHAN];
  logic [PTR_W-1:0]               rd_ptr_q [block_pkg::NUM_CHAN];
  logic [CNT_W-1:0]               occ_q    [block_pkg::NUM_CHAN];
  logic [block_pkg::NUM_CHAN-1:0] push_hit;
  logic [block_pkg::NUM_CHAN-1:0] pop_hit;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_comb
  begin
    for (int c = 0; c < block_pkg::NUM_CHAN; c++)
    begin
      push_hit[c] = wr.push && (wr.push_chan == block_pkg::chan_t'(c));
      pop_hit[c]  = rd.pop && (rd.pop_chan == block_pkg::chan_t'(c));
      wr.full[c]  = (occ_q[c] == CNT_W'(FIFO_DEPTH));
      rd.empty[c] = (occ_q[c] == '0);
    end
  end

  assign rd.pop_data = mem_q[rd.pop_chan][rd_ptr_q[rd.pop_chan]];   // Fall-through head

  always_ff @(posedge CLK_n)
    if (wr.push)
      mem_q[wr.push_chan][wr_ptr_q[wr.push_chan]] <= wr.push_data;

  // --------------------
  // Pointers and counts
  // --------------------
  always_ff @(posedge CLK_n)
  begin
    for (int c = 0; c < block_pkg::NUM_CHAN; c++)
    begin
      if (!RST_MASTER)
      begin
        wr_ptr_q[c] <= '0;
        rd_ptr_q[c] <= '0;
        occ_q[c]    <= '0;
      end
      else
      begin
        if (push_hit[c])
          wr_ptr_q[c] <= next_ptr(wr_ptr_q[c]);
        if (pop_hit[c])
          rd_ptr_q[c] <= next_ptr(rd_ptr_q[c]);
        occ_q[c] <= occ_q[c] + CNT_W'(push_hit[c]) - CNT_W'(pop_hit[c]);
      end
    end
  end

  a_no_overflow: assert property (@(posedge CLK_n) disable iff (!RST_MASTER)
    wr.push |-> !wr.full[wr.push_chan])
    else $error("Push to a full channel");

  a_no_underflow: assert property (@(posedge CLK_n) disable iff (!RST_MASTER)
    rd.pop |-> !rd.empty[rd.pop_chan])
    else $error("Pop from an empty channel");

endmodule

// ==== logic/chan_fifo_if.sv ====
`timescale 1ns/1ps

interface chan_fifo_if;
  logic                           push;
  block_pkg::chan_t               push_chan;
  block_pkg::word_t               push_data;
  logic [block_pkg::NUM_CHAN-1:0] full;
  logic                           pop;
  block_pkg::chan_t               pop_chan;
  logic [block_pkg::NUM_CHAN-1:0] empty;
  block_pkg::word_t               pop_data;   // Head of pop_chan

  modport writer (output push, push_chan, push_data, input full);
  modport reader (output pop, pop_chan, input empty, pop_data);

  // Bank side of each half
  modport bank_wr (input push, push_chan, push_data, output full);
  modport bank_rd (input pop, pop_chan, output empty, pop_data);

endinterface

// ==== logic/drain_mover.sv ====
`timescale 1ns/1ps

module drain_mover
(
  input  logic          CLK_n,
  input  logic          RST_MASTER,
  block_job_if.mover    job,
  mem_port_if.requester mem,
  chan_fifo_if.writer   dst
);

  block_pkg::mover_state_t state_q;
  block_pkg::chan_t        chan_q;
  block_pkg::addr_t        addr_q;
  block_pkg::count_t       count_q;
  block_pkg::count_t       sent_q;
  logic                    req_q;
  logic                    ack_q;
  logic                    finish;

  assign finish = (sent_q == count_q) || dst.full[chan_q];   // Done or no room

  // Read word goes straight into the channel on ack
  assign dst.push      = (state_q == block_pkg::MEM_REQ) && mem.ack;
  assign dst.push_chan = chan_q;
  assign dst.push_data = mem.rdata;

  assign mem.req   = req_q;
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_q + block_pkg::addr_t'(sent_q);
  assign mem.wdata = '0;
  assign job.ack   = ack_q;
  assign job.sent  = sent_q;

  always_ff @(posedge CLK_n)
    if ((state_q == block_pkg::IDLE) && job.req)
    begin
      chan_q  <= job.chan;
      addr_q  <= job.addr;
      count_q <= job.count;
    end

  always_ff @(posedge CLK_n)
  begin
    if (!RST_MASTER)
    begin
      state_q <= block_pkg::IDLE;
      sent_q  <= '0;
      req_q   <= 1'b0;
      ack_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        block_pkg::IDLE:
          if (job.req)
          begin
            sent_q  <= '0;
            state_q <= block_pkg::LOAD;
          end
        block_pkg::LOAD:
          if (finish)
          begin
            ack_q   <= 1'b1;
            state_q <= block_pkg::DONE;
          end
          else
          begin
            req_q   <= 1'b1;
            state_q <= block_pkg::MEM_REQ;
          end
        block_pkg::MEM_REQ:
          if (mem.ack)
          begin
            req_q   <= 1'b0;
            sent_q  <= sent_q + 1'b1;
            state_q <= block_pkg::MEM_WAIT;
          end
        block_pkg::MEM_WAIT:
          if (!mem.ack)
            state_q <= block_pkg::LOAD;   // Four-phase closed
        block_pkg::DONE:
          if (!job.req)
          begin
            ack_q   <= 1'b0;
            state_q <= block_pkg::IDLE;
          end
        default:
          state_q <= block_pkg::IDLE;
      endcase
    end
  end

endmodule

// ==== logic/fill_mover.sv ====
`timescale 1ns/1ps

module fill_mover
(
  input  logic          CLK_n,
  input  logic          RST_MASTER,
  block_job_if.mover    job,
  chan_fifo_if.reader   src,
  mem_port_if.requester mem
);

  block_pkg::mover_state_t state_q;
  block_pkg::chan_t        chan_q;
  block_pkg::addr_t        addr_q;
  block_pkg::count_t       count_q;
  block_pkg::count_t       sent_q;
  block_pkg::word_t        data_q;
  logic                    req_q;
  logic                    ack_q;
  logic                    finish;

  assign finish = (sent_q == count_q) || src.empty[chan_q];   // Done or ran dry

  assign src.pop      = (state_q == block_pkg::LOAD) && !finish;
  assign src.pop_chan = chan_q;
  assign mem.req      = req_q;
  assign mem.we       = 1'b1;
  assign mem.addr     = addr_q + block_pkg::addr_t'(sent_q);   // Wraps at 512
  assign mem.wdata    = data_q;
  assign job.ack      = ack_q;
  assign job.sent     = sent_q;

  always_ff @(posedge CLK_n)
  begin
    if ((state_q == block_pkg::IDLE) && job.req)
    begin
      chan_q  <= job.chan;
      addr_q  <= job.addr;
      count_q <= job.count;
    end
    if (src.pop)
      data_q <= src.pop_data;
  end

  always_ff @(posedge CLK_n)
  begin
    if (!RST_MASTER)
    begin
      state_q <= block_pkg::IDLE;
      sent_q  <= '0;
      req_q   <= 1'b0;
      ack_q   <= 1'b0;
    end
    else
    begin
      case (state_q)
        block_pkg::IDLE:
          if (job.req)
          begin
            sent_q  <= '0;
            state_q <= block_pkg::LOAD;
          end
        block_pkg::LOAD:
          if (finish)
          begin
            ack_q   <= 1'b1;
            state_q <= block_pkg::DONE;
          end
          else
          begin
            req_q   <= 1'b1;   // Word is popped this cycle
            state_q <= block_pkg::MEM_REQ;
          end
        block_pkg::MEM_REQ:
          if (mem.ack)
          begin
            req_q   <= 1'b0;
            sent_q  <= sent_q + 1'b1;
            state_q <= block_pkg::MEM_WAIT;
          end
        block_pkg::MEM_WAIT:
          if (!mem.ack)
            state_q <= block_pkg::LOAD;
        block_pkg::DONE:
          if (!job.req)
          begin
            ack_q   <= 1'b0;
            state_q <= block_pkg::IDLE;
          end
        default:
          state_q <= block_pkg::IDLE;
      endcase
    end
  end

  a_ack_after_req: assert property (@(posedge CLK_n) disable iff (!RST_MASTER)
    $rose(mem.ack) |-> mem.req)
    else $error("Memory ack without a request");

endmodule

// ==== logic/mem_port_if.sv ====
`timescale 1ns/1ps

interface mem_port_if;
  logic             req;
  logic             we;
  block_pkg::addr_t addr;
  block_pkg::word_t wdata;
  logic             ack;
  block_pkg::word_t rdata;   // Valid with ack on a read

  modport requester
  (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport arbiter
  (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

// ==== sim/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
  checks++;
  if (actual !== expected)
  begin
    errors++;
    $display("CHECK FAILED at %0t: %s expected 0x%0h, got 0x%0h",
             $time, name, expected, actual);
  end
endtask

task automatic report_test(input string name, input int errs_before);
  tests_run++;
  if (errors == errs_before)
    $display("%s: ok", name);
  else
    $display("%s: %0d errors", name, errors - errs_before);
endtask

// --------------------
// Drivers
// --------------------
task automatic push_words(input block_pkg::chan_t chan, input int n);
  block_pkg::word_t w;
  for (int i = 0; i < n; i++)
  begin
    if (o_in_full[chan])
    begin
      errors++;
      $display("Inbound channel %0d went full after %0d of %0d words", chan, i, n);
      break;
    end
    w = $random(seed);
    stage_q.push_back(w);
    i_in_push = 1'b1;
    i_in_chan = chan;
    i_in_data = w;
    @(negedge CLK_n);
  end
  i_in_push = 1'b0;
endtask

task automatic start_fill(input block_pkg::chan_t chan, input block_pkg::addr_t addr,
                          input block_pkg::count_t count);
  i_fill_chan  = chan;
  i_fill_addr  = addr;
  i_fill_count = count;
  i_fill_req   = 1'b1;
endtask

task automatic start_drain(input block_pkg::chan_t chan, input block_pkg::addr_t addr,
                           input block_pkg::count_t count);
  i_drain_chan  = chan;
  i_drain_addr  = addr;
  i_drain_count = count;
  i_drain_req   = 1'b1;
endtask

// Waits for the acks of the running jobs, then closes both handshakes
task automatic close_jobs(input bit fill_on, input bit drain_on,
                          input block_pkg::count_t fill_exp,
                          input block_pkg::count_t drain_exp);
  while ((fill_on && !o_fill_ack) || (drain_on && !o_drain_ack))
    @(negedge CLK_n);
  if (fill_on)
    check_value("o_fill_sent", fill_exp, o_fill_sent);
  if (drain_on)
    check_value("o_drain_sent", drain_exp, o_drain_sent);
  i_fill_req  = 1'b0;
  i_drain_req = 1'b0;
  @(negedge CLK_n);
  while (o_fill_ack || o_drain_ack)
    @(negedge CLK_n);
endtask

task automatic pop_and_compare(input block_pkg::chan_t chan, input int n);
  block_pkg::word_t expected;
  i_out_chan = chan;
  i_out_pop  = 1'b0;
  @(negedge CLK_n);
  for (int i = 0; i < n; i++)
  begin
    if (o_out_empty[chan] || (stage_q.size() == 0))
    begin
      errors++;
      $display("Word %0d of %0d missing on outbound channel %0d", i, n, chan);
      break;
    end
    expected = stage_q.pop_front();
    check_value($sformatf("o_out_data[%0d]", i), expected, o_out_data);
    i_out_pop = 1'b1;   // Head shown before the pop
    @(negedge CLK_n);
  end
  i_out_pop = 1'b0;
  check_value("o_out_empty[chan]", 1'b1, o_out_empty[chan]);
endtask

// --------------------
// Directed tests
// --------------------
task automatic reset_state_check();
  int errs_before;
  errs_before = errors;
  check_value("o_fill_ack", 1'b0, o_fill_ack);
  check_value("o_drain_ack", 1'b0, o_drain_ack);
  check_value("o_fill_sent", 6'd0, o_fill_sent);
  check_value("o_drain_sent", 6'd0, o_drain_sent);
  check_value("o_out_empty", 4'hF, o_out_empty);
  check_value("o_in_full", 4'h0, o_in_full);
  report_test("reset_state", errs_before);
endtask

task automatic round_trip();
  int errs_before;
  errs_before = errors;
  push_words(2'd1, 6);
  start_fill(2'd1, 9'd20, 6'd6);
  close_jobs(1'b1, 1'b0, 6'd6, 6'd0);
  start_drain(2'd2, 9'd20, 6'd6);
  close_jobs(1'b0, 1'b1, 6'd0, 6'd6);
  pop_and_compare(2'd2, 6);
  report_test("round_trip", errs_before);
endtask

task automatic early_fill_stop();
  int errs_before;
  errs_before = errors;
  push_words(2'd0, 3);
  start_fill(2'd0, 9'd40, 6'd10);   // Channel runs dry after 3
  close_jobs(1'b1, 1'b0, 6'd3, 6'd0);
  start_drain(2'd1, 9'd40, 6'd3);
  close_jobs(1'b0, 1'b1, 6'd0, 6'd3);
  pop_and_compare(2'd1, 3);
  report_test("early_fill_stop", errs_before);
endtask

task automatic wrapped_drain_stop();
  int errs_before;
  errs_before = errors;
  push_words(2'd2, FIFO_DEPTH);
  check_value("o_in_full", 4'b0100, o_in_full);
  start_fill(2'd2, 9'd508, 6'(FIFO_DEPTH));   // 508..511 then 0..3
  close_jobs(1'b1, 1'b0, 6'(FIFO_DEPTH), 6'd0);
  start_drain(2'd3, 9'd508, 6'd12);
  close_jobs(1'b0, 1'b1, 6'd0, 6'(FIFO_DEPTH));
  pop_and_compare(2'd3, FIFO_DEPTH);
  report_test("wrapped_drain_stop", errs_before);
endtask

task automatic concurrent_jobs();
  int errs_before;
  errs_before = errors;
  push_words(2'd0, 5);
  start_fill(2'd0, 9'd100, 6'd5);   // Known words at 100..104
  close_jobs(1'b1, 1'b0, 6'd5, 6'd0);
  push_words(2'd3, 5);
  start_fill(2'd3, 9'd200, 6'd5);
  start_drain(2'd0, 9'd100, 6'd5);
  close_jobs(1'b1, 1'b1, 6'd5, 6'd5);
  pop_and_compare(2'd0, 5);
  start_drain(2'd1, 9'd200, 6'd5);
  close_jobs(1'b0, 1'b1, 6'd0, 6'd5);
  pop_and_compare(2'd1, 5);
  report_test("concurrent_jobs", errs_before);
endtask

`endif

// ==== sim/tb_block_mover.sv ====
`timescale 1ns/1ps

module tb_block_mover;

  localparam int FIFO_DEPTH     = 8;
  localparam int TEST_CYCLES    = 1500;                  // Rough length of all five tests
  localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES + 500;

  logic                           CLK_n;
  logic                           RST_MASTER;
  logic                           i_in_push;
  block_pkg::chan_t               i_in_chan;
  block_pkg::word_t               i_in_data;
  logic [block_pkg::NUM_CHAN-1:0] o_in_full;
  logic                           i_out_pop;
  block_pkg::chan_t               i_out_chan;
  block_pkg::word_t               o_out_data;
  logic [block_pkg::NUM_CHAN-1:0] o_out_empty;
  logic                           i_fill_req;
  block_pkg::chan_t               i_fill_chan;
  block_pkg::addr_t               i_fill_addr;
  block_pkg::count_t              i_fill_count;
  logic                           o_fill_ack;
  block_pkg::count_t              o_fill_sent;
  logic                           i_drain_req;
  block_pkg::chan_t               i_drain_chan;
  block_pkg::addr_t               i_drain_addr;
  block_pkg::count_t              i_drain_count;
  logic                           o_drain_ack;
  block_pkg::count_t              o_drain_sent;

  integer                         seed;
  int                             errors      = 0;
  int                             checks      = 0;
  int                             tests_run   = 0;
  int                             cycle_count = 0;
  block_pkg::word_t               stage_q[$];   // Pushed words not yet popped back

  block_mover_top #(.FIFO_DEPTH(FIFO_DEPTH)) UUT
  (
    .CLK_n         (CLK_n),
    .RST_MASTER    (RST_MASTER),
    .i_in_push     (i_in_push),
    .i_in_chan     (i_in_chan),
    .i_in_data     (i_in_data),
    .o_in_full     (o_in_full),
    .i_out_pop     (i_out_pop),
    .i_out_chan    (i_out_chan),
    .o_out_data    (o_out_data),
    .o_out_empty   (o_out_empty),
    .i_fill_req    (i_fill_req),
    .i_fill_chan   (i_fill_chan),
    .i_fill_addr   (i_fill_addr),
    .i_fill_count  (i_fill_count),
    .o_fill_ack    (o_fill_ack),
    .o_fill_sent   (o_fill_sent),
    .i_drain_req   (i_drain_req),
    .i_drain_chan  (i_drain_chan),
    .i_drain_addr  (i_drain_addr),
    .i_drain_count (i_drain_count),
    .o_drain_ack   (o_drain_ack),
    .o_drain_sent  (o_drain_sent)
  );

  `include "tb_tasks.svh"

  initial
  begin
    CLK_n = 1'b0;
    forever #50 CLK_n = ~CLK_n;   // 100 ns period
  end

  // --------------------
  // Watchdog
  // --------------------
  always @(posedge CLK_n)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial
  begin
    $timeformat(-9, 0, " ns", 0);
    seed          = 6;
    RST_MASTER    = 1'b0;
    i_in_push     = 1'b0;
    i_in_chan     = '0;
    i_in_data     = '0;
    i_out_pop     = 1'b0;
    i_out_chan    = '0;
    i_fill_req    = 1'b0;
    i_fill_chan   = '0;
    i_fill_addr   = '0;
    i_fill_count  = '0;
    i_drain_req   = 1'b0;
    i_drain_chan  = '0;
    i_drain_addr  = '0;
    i_drain_count = '0;
    repeat (5) @(negedge CLK_n);
    RST_MASTER = 1'b1;
    @(negedge CLK_n);

    reset_state_check();
    round_trip();
    early_fill_stop();
    wrapped_drain_stop();
    concurrent_jobs();

    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule
